// ==== logic/core_defs.svh ====
// datapath widths, reset address, fetch step and RV32I major opcodes
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define XLEN 32
// register index width
`define REG_AW 5

// first fetch address and fetch increment
`define RESET_PC 32'h0000_0000
`define INST_STEP 32'd4

// major opcodes in bits [6:0]
`define OP_ALU 7'b0110011
`define OP_ALUI 7'b0010011
`define OP_LUI 7'b0110111
`define OP_AUIPC 7'b0010111
`define OP_BRANCH 7'b1100011
`define OP_JAL 7'b1101111
`define OP_JALR 7'b1100111

`endif

// ==== logic/core_pkg.sv ====
// ALU and branch selectors, forwarding select, decoded instruction and pipeline register types
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    // BR_NONE for anything that is not a conditional branch
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`XLEN-1:0]   imm;
        alu_op_e            alu_op;
        br_op_e             br_op;
        logic               use_imm;
        // pc as operand a for auipc and the jump link
        logic               use_pc_a;
        logic               writes_rd;
        logic               is_jal;
        logic               is_jalr;
        logic               valid;
    } dec_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        dec_t             dec;
        logic [`XLEN-1:0] rs1_val;
        logic [`XLEN-1:0] rs2_val;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== logic/fetch_unit.sv ====
// program counter, instruction request and IF/ID register
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_ready,
    input  logic [`XLEN-1:0] inst_data,
    input  logic             flush,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic             inst_req,
    output logic [`XLEN-1:0] inst_addr,
    output core_pkg::if_id_t if_id
);

    logic             req_q;
    logic [`XLEN-1:0] pc_q;
    logic             valid_q;
    logic [`XLEN-1:0] word_pc_q;
    logic [`XLEN-1:0] inst_q;
    logic             take;

    // a response that lands with a redirect belongs to the old path
    assign take = req_q & inst_ready & ~flush;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_q   <= 1'b0;
            pc_q    <= `RESET_PC;
            valid_q <= 1'b0;
        end else begin
            // request stays up from the first edge after reset
            req_q   <= 1'b1;
            valid_q <= take;
            if (flush) begin
                pc_q <= redirect_pc;
            end else if (take) begin
                pc_q <= pc_q + `INST_STEP;
            end
        end
    end

    // captured word and its address
    always_ff @(posedge clk) begin
        if (take) begin
            word_pc_q <= pc_q;
            inst_q    <= inst_data;
        end
    end

    assign inst_req  = req_q;
    assign inst_addr = pc_q;
    assign if_id     = '{valid: valid_q, pc: word_pc_q, inst: inst_q};

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
// RV32I decoder, operand forwarding select and ID/EX register
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::if_id_t   if_id,
    input  core_pkg::fwd_sel_e rs1_sel,
    input  core_pkg::fwd_sel_e rs2_sel,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    input  logic [`XLEN-1:0]   ex_result,
    input  logic [`XLEN-1:0]   wb_data,
    input  logic               flush,
    output logic [`REG_AW-1:0] id_rs1,
    output logic [`REG_AW-1:0] id_rs2,
    output core_pkg::id_ex_t   id_ex
);

    import core_pkg::*;

    logic [`XLEN-1:0] inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    dec_t             dec;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             valid_q;
    logic [`XLEN-1:0] pc_q;
    dec_t             dec_q;
    logic [`XLEN-1:0] rs1_q;
    logic [`XLEN-1:0] rs2_q;

    // alt picks sub or sra
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] pick_operand(input fwd_sel_e sel,
                                                      input logic [`XLEN-1:0] rf,
                                                      input logic [`XLEN-1:0] ex,
                                                      input logic [`XLEN-1:0] wb);
        case (sel)
            FWD_EX:  return ex;
            FWD_WB:  return wb;
            default: return rf;
        endcase
    endfunction

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // sign-extended immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm_i;
        dec.alu_op = ALU_ADD;
        dec.br_op  = BR_NONE;
        case (opcode)
            `OP_ALU: begin
                dec.alu_op    = alu_from_f3(funct3, funct7[5]);
                dec.writes_rd = 1'b1;
                dec.valid     = (funct7 == 7'b0000000) ||
                                (funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5));
            end
            `OP_ALUI: begin
                // only srai has the alternate bit, addi uses it as immediate
                dec.alu_op    = alu_from_f3(funct3, funct3 == 3'd5 && funct7[5]);
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
                if (funct3 == 3'd1) begin
                    dec.valid = (funct7 == 7'b0000000);
                end else if (funct3 == 3'd5) begin
                    dec.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    dec.valid = 1'b1;
                end
            end
            `OP_LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
                dec.valid     = 1'b1;
            end
            `OP_AUIPC: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.use_pc_a  = 1'b1;
                dec.writes_rd = 1'b1;
                dec.valid     = 1'b1;
            end
            `OP_BRANCH: begin
                dec.imm   = imm_b;
                dec.valid = 1'b1;
                case (funct3)
                    3'd0:    dec.br_op = BR_EQ;
                    3'd1:    dec.br_op = BR_NE;
                    3'd4:    dec.br_op = BR_LT;
                    3'd5:    dec.br_op = BR_GE;
                    3'd6:    dec.br_op = BR_LTU;
                    3'd7:    dec.br_op = BR_GEU;
                    default: dec.valid = 1'b0;
                endcase
            end
            `OP_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.use_pc_a  = 1'b1;
                dec.writes_rd = 1'b1;
                dec.valid     = 1'b1;
            end
            `OP_JALR: begin
                dec.is_jalr   = 1'b1;
                dec.use_pc_a  = 1'b1;
                dec.writes_rd = 1'b1;
                dec.valid     = (funct3 == 3'd0);
            end
            default: begin
                // unknown word leaves valid low and runs as a bubble
                dec.valid = 1'b0;
            end
        endcase
    end

    assign id_rs1  = dec.rs1;
    assign id_rs2  = dec.rs2;
    assign rs1_val = pick_operand(rs1_sel, rs1_data, ex_result, wb_data);
    assign rs2_val = pick_operand(rs2_sel, rs2_data, ex_result, wb_data);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= if_id.valid & dec.valid & ~flush;
        end
    end

    // jumps carry the step in the rs2 slot so the ALU forms pc + 4
    always_ff @(posedge clk) begin
        pc_q  <= if_id.pc;
        dec_q <= dec;
        rs1_q <= rs1_val;
        rs2_q <= (dec.is_jal | dec.is_jalr) ? `INST_STEP : rs2_val;
    end

    assign id_ex = '{valid: valid_q, pc: pc_q, dec: dec_q, rs1_val: rs1_q, rs2_val: rs2_q};

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// integer register array with x0 at zero, and the writeback latch
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic [`REG_AW-1:0] id_rs1,
    input  logic [`REG_AW-1:0] id_rs2,
    input  logic               ex_wen,
    input  logic [`REG_AW-1:0] ex_rd,
    input  logic [`XLEN-1:0]   ex_result,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    output logic               wb_en,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data
);

    logic [`XLEN-1:0] regs [0:(1 << `REG_AW)-1];

    // writeback stage
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
        // latch reaches the array one edge later, wb_en never set for x0
        if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (id_rs1 == '0) ? '0 : regs[id_rs1];
    assign rs2_data = (id_rs2 == '0) ? '0 : regs[id_rs2];

endmodule

`default_nettype wire

// ==== logic/ex_alu.sv ====
// execute ALU, destination value for every writing instruction
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ex_alu (
    input  core_pkg::id_ex_t   id_ex,
    output logic               ex_wen,
    output logic [`REG_AW-1:0] ex_rd,
    output logic [`XLEN-1:0]   ex_result
);

    import core_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [SHW-1:0]   shamt;

    assign op_a  = id_ex.dec.use_pc_a ? id_ex.pc : id_ex.rs1_val;
    assign op_b  = id_ex.dec.use_imm ? id_ex.dec.imm : id_ex.rs2_val;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (id_ex.dec.alu_op)
            ALU_ADD:  ex_result = op_a + op_b;
            ALU_SUB:  ex_result = op_a - op_b;
            ALU_AND:  ex_result = op_a & op_b;
            ALU_OR:   ex_result = op_a | op_b;
            ALU_XOR:  ex_result = op_a ^ op_b;
            ALU_SLL:  ex_result = op_a << shamt;
            ALU_SRL:  ex_result = op_a >> shamt;
            ALU_SRA:  ex_result = $signed(op_a) >>> shamt;
            ALU_SLT:  ex_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: ex_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            default:  ex_result = op_b;
        endcase
    end

    // bubbles and x0 targets never write
    assign ex_wen = id_ex.valid & id_ex.dec.writes_rd & (id_ex.dec.rd != '0);
    assign ex_rd  = id_ex.dec.rd;

endmodule

`default_nettype wire

// ==== logic/ex_branch.sv ====
// branch condition and jump target
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ex_branch (
    input  core_pkg::id_ex_t id_ex,
    output logic             br_taken,
    output logic [`XLEN-1:0] br_target
);

    import core_pkg::*;

    logic             eq;
    logic             lt;
    logic             ltu;
    logic             cond;
    logic [`XLEN-1:0] jalr_sum;

    assign eq  = (id_ex.rs1_val == id_ex.rs2_val);
    assign lt  = ($signed(id_ex.rs1_val) < $signed(id_ex.rs2_val));
    assign ltu = (id_ex.rs1_val < id_ex.rs2_val);

    always_comb begin
        case (id_ex.dec.br_op)
            BR_EQ:   cond = eq;
            BR_NE:   cond = ~eq;
            BR_LT:   cond = lt;
            BR_GE:   cond = ~lt;
            BR_LTU:  cond = ltu;
            BR_GEU:  cond = ~ltu;
            default: cond = 1'b0;
        endcase
    end

    assign br_taken = id_ex.valid & (id_ex.dec.is_jal | id_ex.dec.is_jalr | cond);

    // jalr drops bit zero of the sum
    assign jalr_sum  = id_ex.rs1_val + id_ex.dec.imm;
    assign br_target = id_ex.dec.is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0}
                                         : id_ex.pc + id_ex.dec.imm;

endmodule

`default_nettype wire

// ==== logic/pipe_control.sv ====
// forwarding select, flush and fetch redirect
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module pipe_control (
    input  logic               [`REG_AW-1:0] id_rs1,
    input  logic               [`REG_AW-1:0] id_rs2,
    input  logic                             ex_wen,
    input  logic               [`REG_AW-1:0] ex_rd,
    input  logic                             wb_en,
    input  logic               [`REG_AW-1:0] wb_rd,
    input  logic                             br_taken,
    input  logic               [`XLEN-1:0]   br_target,
    output core_pkg::fwd_sel_e               rs1_sel,
    output core_pkg::fwd_sel_e               rs2_sel,
    output logic                             flush,
    output logic               [`XLEN-1:0]   redirect_pc
);

    import core_pkg::*;

    // youngest producer wins, execute before the writeback latch
    function automatic fwd_sel_e pick_src(input logic [`REG_AW-1:0] rs,
                                          input logic               e_wen,
                                          input logic [`REG_AW-1:0] e_rd,
                                          input logic               w_en,
                                          input logic [`REG_AW-1:0] w_rd);
        if (rs == '0) begin
            return FWD_RF;
        end else if (e_wen && e_rd == rs) begin
            return FWD_EX;
        end else if (w_en && w_rd == rs) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign rs1_sel = pick_src(id_rs1, ex_wen, ex_rd, wb_en, wb_rd);
    assign rs2_sel = pick_src(id_rs2, ex_wen, ex_rd, wb_en, wb_rd);

    // taken branch kills IF/ID and ID/EX at the next edge
    assign flush       = br_taken;
    assign redirect_pc = br_target;

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
// three-stage RV32I core top, fetch, decode and execute with writeback
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module cpu_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_ready,
    input  logic [`XLEN-1:0]   inst_data,
    output logic               inst_req,
    output logic [`XLEN-1:0]   inst_addr,
    output logic               wb_en,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data
);

    import core_pkg::*;

    if_id_t             if_id;
    id_ex_t             id_ex;
    fwd_sel_e           rs1_sel;
    fwd_sel_e           rs2_sel;
    logic               flush;
    logic [`XLEN-1:0]   redirect_pc;
    logic [`REG_AW-1:0] id_rs1;
    logic [`REG_AW-1:0] id_rs2;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic               ex_wen;
    logic [`REG_AW-1:0] ex_rd;
    logic [`XLEN-1:0]   ex_result;
    logic               br_taken;
    logic [`XLEN-1:0]   br_target;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .inst_ready  (inst_ready),
        .inst_data   (inst_data),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .inst_req    (inst_req),
        .inst_addr   (inst_addr),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst       (rst),
        .if_id     (if_id),
        .rs1_sel   (rs1_sel),
        .rs2_sel   (rs2_sel),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .ex_result (ex_result),
        .wb_data   (wb_data),
        .flush     (flush),
        .id_rs1    (id_rs1),
        .id_rs2    (id_rs2),
        .id_ex     (id_ex)
    );

    reg_file u_regs (
        .clk       (clk),
        .rst       (rst),
        .id_rs1    (id_rs1),
        .id_rs2    (id_rs2),
        .ex_wen    (ex_wen),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    ex_alu u_alu (
        .id_ex     (id_ex),
        .ex_wen    (ex_wen),
        .ex_rd     (ex_rd),
        .ex_result (ex_result)
    );

    ex_branch u_branch (
        .id_ex     (id_ex),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    pipe_control u_ctrl (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_wen      (ex_wen),
        .ex_rd       (ex_rd),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== tb/tb_cpu_core.sv ====
// testbench for cpu_core with instruction memory model, writeback checker and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module tb_cpu_core;

    logic               clk = 1'b0;
    logic               rst;
    logic               inst_ready = 1'b0;
    logic [`XLEN-1:0]   inst_data = '0;
    logic               inst_req;
    logic [`XLEN-1:0]   inst_addr;
    logic               wb_en;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_data;

    // word count, program words, trace count, then rd and value pairs
    logic [`XLEN-1:0] data_mem [0:127];
    int               n_words;
    int               n_exp;
    int               exp_base;
    bit               loaded = 1'b0;

    int               errors = 0;
    int               wb_seen = 0;
    int               limit;
    int               total_errors;
    bit               count_bad = 1'b0;
    bit               post_reset_seen = 1'b0;
    bit               first_req_seen = 1'b0;

    // memory model state
    logic [31:0]      lfsr = 32'he01509e6;
    logic [`XLEN-1:0] pend_addr;
    bit               pending = 1'b0;
    int               wait_left;

    cpu_core UUT (
        .clk        (clk),
        .rst        (rst),
        .inst_ready (inst_ready),
        .inst_data  (inst_data),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // two bits give a wait of zero to three cycles
    task automatic draw_wait(output int n);
        n = 0;
        lfsr = lfsr_next(lfsr);
        if (lfsr[0]) n = n + 1;
        lfsr = lfsr_next(lfsr);
        if (lfsr[0]) n = n + 2;
    endtask

    function automatic logic [`XLEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < n_words) begin
            return data_mem[idx + 1];
        end
        // jal x0, 0 past the end of the program
        return 32'h0000_006f;
    endfunction

    task automatic load_program();
        $readmemh("tb/program_input.txt", data_mem);
        if ($isunknown(data_mem[0])) begin
            n_words = 0;
            n_exp   = 0;
        end else begin
            n_words  = int'(data_mem[0]);
            n_exp    = int'(data_mem[n_words + 1]);
            exp_base = n_words + 2;
        end
    endtask

    task automatic check_writeback();
        int               base;
        logic [`REG_AW-1:0] rd_exp;
        logic [`XLEN-1:0]   val_exp;
        assert (wb_rd != '0) else begin
            errors++;
            $display("ERROR @%0t: writeback pulse for x0", $time);
        end
        assert (wb_seen < n_exp) else begin
            errors++;
            $display("ERROR @%0t: extra writeback x%0d = %h", $time, wb_rd, wb_data);
        end
        if (wb_seen < n_exp) begin
            base    = exp_base + 2 * wb_seen;
            rd_exp  = data_mem[base][`REG_AW-1:0];
            val_exp = data_mem[base + 1];
            assert (wb_rd == rd_exp && wb_data == val_exp) else begin
                errors++;
                $display("ERROR @%0t: writeback %0d is x%0d = %h, expected x%0d = %h",
                         $time, wb_seen, wb_rd, wb_data, rd_exp, val_exp);
            end
        end
        wb_seen++;
    endtask

    // instruction memory answering after a random wait
    always @(posedge clk) begin
        #1;
        if (!rst || !inst_req) begin
            inst_ready = 1'b0;
            pending    = 1'b0;
        end else begin
            // fresh request, a redirect, or the last answer was consumed
            if (!pending || inst_addr != pend_addr || inst_ready) begin
                pend_addr = inst_addr;
                pending   = 1'b1;
                draw_wait(wait_left);
            end else if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end
            inst_ready = (wait_left == 0);
            inst_data  = fetch_word(inst_addr);
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            assert (!wb_en && !inst_req) else begin
                errors++;
                $display("ERROR @%0t: wb_en=%b inst_req=%b during reset", $time, wb_en, inst_req);
            end
        end else if (!post_reset_seen) begin
            post_reset_seen = 1'b1;
            assert (!wb_en && !inst_req) else begin
                errors++;
                $display("ERROR @%0t: wb_en=%b inst_req=%b in first cycle after reset",
                         $time, wb_en, inst_req);
            end
        end else begin
            if (inst_req && !first_req_seen) begin
                first_req_seen = 1'b1;
                // program starts at address zero
                assert (inst_addr == 32'h0000_0000) else begin
                    errors++;
                    $display("ERROR @%0t: first fetch address %h", $time, inst_addr);
                end
            end
            if (wb_en) begin
                check_writeback();
            end
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        limit = (n_exp + n_words) * 8 + 8;
        repeat (limit) @(posedge clk);
        $display("timeout: only %0d of %0d writebacks after %0d cycles", wb_seen, n_exp, limit);
        $display("errors: %0d, writebacks: %0d of %0d", errors, wb_seen, n_exp);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst = 1'b0;
        load_program();
        if (n_words == 0 || n_exp == 0) begin
            $display("could not read program words and trace from tb/program_input.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (8) @(posedge clk);
            #1 rst = 1'b1;
            wait (wb_seen >= n_exp);
            // let the tail run to catch stray writebacks
            repeat (16) @(posedge clk);
            assert (wb_seen == n_exp) else begin
                count_bad = 1'b1;
                $display("ERROR @%0t: %0d writebacks seen, %0d expected", $time, wb_seen, n_exp);
            end
            total_errors = errors + int'(count_bad);
            $display("errors: %0d, writebacks: %0d of %0d", total_errors, wb_seen, n_exp);
            if (total_errors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/pipe_control.sv
logic/cpu_core.sv
tb/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cpu_core -f files.f

out=$(./obj_dir/Vtb_cpu_core)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// ==== tb/program_input.txt ====
// hex: program word count, then one word per line from address 0
// hex: writeback count, then rd and value per line in retire order
2b
00500093  // 00 addi x1, x0, 5
ffd08113  // 04 addi x2, x1, -3
002081b3  // 08 add x3, x1, x2
40310233  // 0c sub x4, x2, x3
800002b7  // 10 lui x5, 0x80000
4042d313  // 14 srai x6, x5, 4
0042d393  // 18 srli x7, x5, 4
00209433  // 1c sll x8, x1, x2
001224b3  // 20 slt x9, x4, x1
00123533  // 24 sltu x10, x4, x1
fff24593  // 28 xori x11, x4, -1
0051e633  // 2c or x12, x3, x5
00f67693  // 30 andi x13, x12, 15
00001717  // 34 auipc x14, 1
00108013  // 38 addi x0, x1, 1
00108463  // 3c beq x1, x1, +8 taken
00100a13  // 40 addi x20, x0, 1 skipped
00109463  // 44 bne x1, x1, +8
00124463  // 48 blt x4, x1, +8 taken
00200a13  // 4c addi x20, x0, 2 skipped
00125463  // 50 bge x4, x1, +8
00126463  // 54 bltu x4, x1, +8
00127463  // 58 bgeu x4, x1, +8 taken
00300a13  // 5c addi x20, x0, 3 skipped
008007ef  // 60 jal x15, +8
00400a13  // 64 addi x20, x0, 4 skipped
07000813  // 68 addi x16, x0, 0x70
009808e7  // 6c jalr x17, 9(x16) to 0x78
00500a13  // 70 addi x20, x0, 5 skipped
00600a13  // 74 addi x20, x0, 6 skipped
01178933  // 78 add x18, x15, x17
00208463  // 7c beq x1, x2, +8
00209463  // 80 bne x1, x2, +8 taken
00700a13  // 84 addi x20, x0, 7 skipped
0040c463  // 88 blt x1, x4, +8
0040d463  // 8c bge x1, x4, +8 taken
00800a13  // 90 addi x20, x0, 8 skipped
0040e463  // 94 bltu x1, x4, +8 taken
00900a13  // 98 addi x20, x0, 9 skipped
0040f463  // 9c bgeu x1, x4, +8
00168993  // a0 addi x19, x13, 1
ffffffff  // a4 undecodable, bubble
00198a93  // a8 addi x21, x19, 1
14
01 00000005
02 00000002
03 00000007
04 fffffffb
05 80000000
06 f8000000
07 08000000
08 00000014
09 00000001
0a 00000000
0b 00000004
0c 80000007
0d 00000007
0e 00001034
0f 00000064
10 00000070
11 00000070
12 000000d4
13 00000008
15 00000009
